/* list.f */
+incdir+.
sta_pkg.sv
sta_loader.sv
sta_node_table.sv
sta_relax.sv
sta_path_trace.sv
sta_ctrl.sv
sta_top.sv
tb_sta.sv

/* Makefile */
# Verilator build and run of the STA testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build output"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_sta -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_sta)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* tb_sta_ref.svh */
// STA reference model, longest-path worst delay and path checks for the testbench
`ifndef TB_STA_REF_SVH
`define TB_STA_REF_SVH

// Longest arrival at the sink, repeated relaxation over the loaded edges
function automatic int ref_worst_delay();
	int arr [NUM_NODES];
	bit hit [NUM_NODES];
	int cand;
	int n;
	int e;
	int pass;
	for (n = 0; n < NUM_NODES; n++) begin
		arr[n] = 0;
		hit[n] = 1'b0;
	end
	hit[SRC_NODE] = 1'b1;
	arr[SRC_NODE] = int'(node_delay[SRC_NODE]);
	for (pass = 0; pass < NUM_NODES; pass++) begin
		for (e = 0; e < NUM_EDGES; e++) begin
			if (hit[edge_src[e]]) begin
				cand = arr[edge_src[e]] + int'(node_delay[edge_dst[e]]);
				if (!hit[edge_dst[e]] || cand > arr[edge_dst[e]]) begin
					arr[edge_dst[e]] = cand;
					hit[edge_dst[e]] = 1'b1;
				end
			end
		end
	end
	return arr[SINK_NODE];
endfunction

// Path runs from source to sink over loaded edges only
function automatic bit path_is_valid();
	bit found;
	int i;
	int e;
	if (path_len < 2)
		return 1'b0;
	if (path_buf[0] != SRC_NODE || path_buf[path_len - 1] != SINK_NODE)
		return 1'b0;
	for (i = 0; i < path_len - 1; i++) begin
		found = 1'b0;
		for (e = 0; e < NUM_EDGES; e++) begin
			if (edge_src[e] == path_buf[i] && edge_dst[e] == path_buf[i + 1])
				found = 1'b1;
		end
		if (!found)
			return 1'b0;
	end
	return 1'b1;
endfunction

function automatic int path_delay_sum();
	int sum;
	int i;
	sum = 0;
	for (i = 0; i < path_len; i++)
		sum += int'(node_delay[path_buf[i]]);
	return sum;
endfunction

`endif

/* tb_sta.sv */
// STA testbench checking chain and random DAG runs against a longest-path reference
`timescale 1ns/1ps

module tb_sta
	import sta_pkg::*;
();

	localparam int SEED           = 32'h662e;
	localparam int NUM_TESTS      = 40;
	// Load, 16 sweeps, walk and output, plus slack for pulses and the idle gap
	localparam int TEST_CYCLES    = NUM_EDGES + NUM_NODES * NUM_EDGES + NUM_EDGES + 16;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 20;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     in_valid;
	delay_t   delay;
	node_t    source;
	node_t    destination;
	logic     out_valid;
	arrival_t worst_delay;
	node_t    path;

	// Graph of the current run
	node_t    edge_src    [NUM_EDGES];
	node_t    edge_dst    [NUM_EDGES];
	delay_t   node_delay  [NUM_NODES];
	node_t    chain_nodes [NUM_NODES];
	int       chain_sum;
	bit       is_chain;
	string    test_name;
	arrival_t exp_worst;

	// Collected output burst
	node_t    path_buf [NUM_NODES];
	int       path_len;
	arrival_t got_worst;
	bit       in_burst;
	bit       expect_burst;
	int       runs_checked;
	int       cycle_cnt = 0;

	`include "tb_sta_ref.svh"

	sta_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.delay       (delay),
		.source      (source),
		.destination (destination),
		.out_valid   (out_valid),
		.worst_delay (worst_delay),
		.path        (path)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	//----------------------------------------------------------------------
	// Graph builders
	//----------------------------------------------------------------------
	// Chain 0 -> 2 -> 3 -> ... -> 15 -> 1 loaded back to front with repeats
	task automatic build_chain_graph();
		int i;
		int c;
		chain_nodes[0] = SRC_NODE;
		for (i = 1; i < NUM_NODES - 1; i++)
			chain_nodes[i] = node_t'(i + 1);
		chain_nodes[NUM_NODES - 1] = SINK_NODE;
		chain_sum = 0;
		for (i = 0; i < NUM_NODES; i++) begin
			node_delay[i] = delay_t'($urandom % 16);
			chain_sum += int'(node_delay[i]);
		end
		for (i = 0; i < NUM_EDGES; i++) begin
			if (i < NUM_NODES - 1)
				c = NUM_NODES - 2 - i;
			else
				c = (i - NUM_NODES + 1) % (NUM_NODES - 1);
			edge_src[i] = chain_nodes[c];
			edge_dst[i] = chain_nodes[c + 1];
		end
		is_chain = 1'b1;
	endtask

	// Edges only climb a random rank order, so the graph has no cycles
	task automatic build_random_graph();
		int    order [NUM_NODES];
		int    i;
		int    j;
		int    r;
		int    nxt;
		int    a;
		int    b;
		int    ne;
		node_t tmp;
		order[0] = SRC_NODE;
		for (i = 1; i < NUM_NODES - 1; i++)
			order[i] = i + 1;
		order[NUM_NODES - 1] = SINK_NODE;
		for (i = NUM_NODES - 2; i > 1; i--) begin
			j = 1 + int'($urandom % i);
			r = order[i];
			order[i] = order[j];
			order[j] = r;
		end
		// Guaranteed chain from source to sink
		ne = 0;
		r  = 0;
		while (r < NUM_NODES - 1) begin
			nxt = r + 1 + int'($urandom % 4);
			if (nxt > NUM_NODES - 1)
				nxt = NUM_NODES - 1;
			edge_src[ne] = node_t'(order[r]);
			edge_dst[ne] = node_t'(order[nxt]);
			ne++;
			r = nxt;
		end
		while (ne < NUM_EDGES) begin
			a = int'($urandom % (NUM_NODES - 1));
			b = a + 1 + int'($urandom % (NUM_NODES - 1 - a));
			edge_src[ne] = node_t'(order[a]);
			edge_dst[ne] = node_t'(order[b]);
			ne++;
		end
		for (i = NUM_EDGES - 1; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			tmp = edge_src[i];
			edge_src[i] = edge_src[j];
			edge_src[j] = tmp;
			tmp = edge_dst[i];
			edge_dst[i] = edge_dst[j];
			edge_dst[j] = tmp;
		end
		for (i = 0; i < NUM_NODES; i++)
			node_delay[i] = delay_t'($urandom % 16);
		is_chain = 1'b0;
	endtask

	task automatic drive_run();
		int k;
		for (k = 0; k < NUM_EDGES; k++) begin
			@(posedge clk);
			in_valid    <= 1'b1;
			source      <= edge_src[k];
			destination <= edge_dst[k];
			// Only the first 16 cycles carry a gate delay
			delay       <= (k < NUM_NODES) ? node_delay[k] : delay_t'($urandom);
		end
		@(posedge clk);
		in_valid    <= 1'b0;
		source      <= '0;
		destination <= '0;
		delay       <= '0;
	endtask

	//----------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------
	initial begin
		int t;
		void'($urandom(SEED));
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		delay        = '0;
		source       = '0;
		destination  = '0;
		path_len     = 0;
		in_burst     = 1'b0;
		expect_burst = 1'b0;
		runs_checked = 0;
		is_chain     = 1'b0;
		chain_sum    = 0;
		exp_worst    = '0;
		got_worst    = '0;
		test_name    = "reset";
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (t = 0; t < NUM_TESTS; t++) begin
			if (t == 0) begin
				build_chain_graph();
				test_name = "chain";
			end else begin
				build_random_graph();
				test_name = $sformatf("random %0d", t);
			end
			exp_worst    = arrival_t'(ref_worst_delay());
			expect_burst = 1'b1;
			drive_run();
			while (runs_checked <= t)
				@(posedge clk);
			repeat (3) @(posedge clk);
		end
		$display("all tests passed");
		$finish;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			fail_run("timeout, the DUT did not finish all runs within the cycle limit");
	end

	//----------------------------------------------------------------------
	// Output checking
	//----------------------------------------------------------------------
	task automatic check_burst();
		int i;
		int sum;
		assert (path_is_valid())
			else fail_run($sformatf("%s: path is not made of loaded edges from node 0 to node 1",
				test_name));
		sum = path_delay_sum();
		assert (sum == int'(exp_worst))
			else fail_run($sformatf("mismatch %s path delay sum: expected %0d, actual %0d",
				test_name, exp_worst, sum));
		if (is_chain) begin
			assert (path_len == NUM_NODES)
				else fail_run($sformatf("mismatch %s path length: expected %0d, actual %0d",
					test_name, NUM_NODES, path_len));
			for (i = 0; i < NUM_NODES; i++) begin
				assert (path_buf[i] == chain_nodes[i])
					else fail_run($sformatf("mismatch %s path node %0d: expected %0d, actual %0d",
						test_name, i, chain_nodes[i], path_buf[i]));
			end
			assert (int'(got_worst) == chain_sum)
				else fail_run($sformatf("mismatch %s chain delay: expected %0d, actual %0d",
					test_name, chain_sum, got_worst));
		end
	endtask

	// Outputs are registered on the rising edge and sampled on the falling one
	always @(negedge clk) begin
		if (!rst_n) begin
			assert (!out_valid)
				else fail_run("out_valid high while reset is asserted");
		end else if (out_valid) begin
			assert (expect_burst && !in_valid)
				else fail_run("out_valid high while no run is waiting for its result");
			if (!in_burst) begin
				assert (worst_delay == exp_worst)
					else fail_run($sformatf("mismatch %s worst_delay: expected %0d, actual %0d",
						test_name, exp_worst, worst_delay));
				got_worst = worst_delay;
				path_len  = 0;
				in_burst  = 1'b1;
			end else begin
				assert (worst_delay == '0)
					else fail_run($sformatf("mismatch %s late worst_delay: expected 0, actual %0d",
						test_name, worst_delay));
			end
			assert (path_len < NUM_NODES)
				else fail_run("reported path is longer than the number of nodes");
			path_buf[path_len] = path;
			path_len++;
		end else begin
			assert (worst_delay == '0)
				else fail_run($sformatf("mismatch %s idle worst_delay: expected 0, actual %0d",
					test_name, worst_delay));
			if (in_burst) begin
				check_burst();
				in_burst     = 1'b0;
				expect_burst = 1'b0;
				runs_checked++;
			end
		end
	end

endmodule

/* sta_top.sv */
// STA top level, connects controller, workers and the shared node table
`timescale 1ns/1ps

module sta_top
	import sta_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  delay_t   delay,
	input  node_t    source,
	input  node_t    destination,
	output logic     out_valid,
	output arrival_t worst_delay,
	output node_t    path
);

	logic        load_done;
	logic        relax_start;
	logic        relax_done;
	logic        trace_start;
	logic        trace_done;
	edge_idx_t   edge_idx;
	edge_t       edge_rd;
	node_wr_t    load_wr;
	node_wr_t    relax_wr;
	node_entry_t src_entry;
	node_entry_t dst_entry;
	delay_t      dst_delay;
	node_t       trace_node;
	node_entry_t trace_entry;

	sta_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.load_done   (load_done),
		.relax_done  (relax_done),
		.trace_done  (trace_done),
		.relax_start (relax_start),
		.trace_start (trace_start)
	);

	sta_loader u_loader (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.delay       (delay),
		.source      (source),
		.destination (destination),
		.edge_idx    (edge_idx),
		.edge_rd     (edge_rd),
		.node_wr     (load_wr),
		.load_done   (load_done)
	);

	// Port A and the destination port follow the edge under relaxation
	sta_node_table u_node_table (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_wr     (load_wr),
		.relax_wr    (relax_wr),
		.rd_node_a   (edge_rd.src),
		.rd_node_b   (trace_node),
		.rd_a        (src_entry),
		.rd_b        (trace_entry),
		.rd_dst      (dst_entry),
		.rd_dst_node (edge_rd.dst),
		.delay_rd    (dst_delay)
	);

	sta_relax u_relax (
		.clk         (clk),
		.rst_n       (rst_n),
		.relax_start (relax_start),
		.edge_rd     (edge_rd),
		.src_entry   (src_entry),
		.dst_entry   (dst_entry),
		.dst_delay   (dst_delay),
		.edge_idx    (edge_idx),
		.relax_wr    (relax_wr),
		.relax_done  (relax_done)
	);

	sta_path_trace u_path_trace (
		.clk         (clk),
		.rst_n       (rst_n),
		.trace_start (trace_start),
		.rd_entry    (trace_entry),
		.rd_node     (trace_node),
		.out_valid   (out_valid),
		.worst_delay (worst_delay),
		.path        (path),
		.trace_done  (trace_done)
	);

endmodule

/* sta_ctrl.sv */
// STA phase controller that sequences load, relax and trace
`timescale 1ns/1ps

module sta_ctrl
	import sta_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic load_done,
	input  logic relax_done,
	input  logic trace_done,
	output logic relax_start,
	output logic trace_start
);

	sta_state_t state;
	sta_state_t state_nx;

	// Walk and stream run under OUTPUT after the one-cycle TRACE kick-off
	always_comb begin
		state_nx = state;
		case (state)
			IDLE:    if (in_valid) state_nx = LOAD;
			LOAD:    if (load_done) state_nx = RELAX;
			RELAX:   if (relax_done) state_nx = TRACE;
			TRACE:   state_nx = OUTPUT;
			OUTPUT:  if (trace_done) state_nx = IDLE;
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			relax_start <= 1'b0;
			trace_start <= 1'b0;
		end else begin
			state       <= state_nx;
			relax_start <= (state == LOAD) && load_done;
			trace_start <= (state == RELAX) && relax_done;
		end
	end

	//----------------------------------------------------------------------
	// Done pulses only arrive in the phase that waits for them
	//----------------------------------------------------------------------
	a_load_done: assert property (@(posedge clk) disable iff (!rst_n)
		load_done |-> (state == LOAD))
		else $error("load_done outside the load phase");

	a_relax_done: assert property (@(posedge clk) disable iff (!rst_n)
		relax_done |-> (state == RELAX))
		else $error("relax_done outside the relax phase");

	a_trace_done: assert property (@(posedge clk) disable iff (!rst_n)
		trace_done |-> (state == OUTPUT))
		else $error("trace_done outside the output phase");

endmodule

/* sta_path_trace.sv */
// STA path tracer, walks predecessors back from the sink and streams the path forwards
`timescale 1ns/1ps

module sta_path_trace
	import sta_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        trace_start,
	input  node_entry_t rd_entry,
	output node_t       rd_node,
	output logic        out_valid,
	output arrival_t    worst_delay,
	output node_t       path,
	output logic        trace_done
);

	typedef enum logic [1:0] {
		TR_IDLE,
		TR_WALK,
		TR_OUT
	} tr_state_t;

	tr_state_t st;
	node_t     cur;
	node_t     stack [NUM_NODES];
	logic [4:0] sp;
	logic [4:0] sp_dec;
	arrival_t  worst_q;
	logic      first_q;

	assign rd_node = cur;
	assign sp_dec  = sp - 5'd1;

	// Push every visited node, sink first
	always_ff @(posedge clk) begin
		if (st == TR_WALK)
			stack[sp[3:0]] <= cur;
	end

	//----------------------------------------------------------------------
	// Walk and stream
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			st          <= TR_IDLE;
			cur         <= SINK_NODE;
			sp          <= '0;
			worst_q     <= '0;
			first_q     <= 1'b0;
			out_valid   <= 1'b0;
			worst_delay <= '0;
			path        <= '0;
			trace_done  <= 1'b0;
		end else begin
			out_valid   <= 1'b0;
			worst_delay <= '0;
			path        <= '0;
			trace_done  <= 1'b0;
			case (st)
				TR_IDLE: begin
					if (trace_start) begin
						st  <= TR_WALK;
						cur <= SINK_NODE;
						sp  <= '0;
					end
				end
				TR_WALK: begin
					sp <= sp + 5'd1;
					// Sink is read on the first walk cycle
					if (sp == '0)
						worst_q <= rd_entry.arrival;
					if (cur == SRC_NODE || sp == 5'(NUM_NODES - 1)) begin
						st      <= TR_OUT;
						first_q <= 1'b1;
					end else begin
						cur <= rd_entry.pred;
					end
				end
				TR_OUT: begin
					if (sp != '0) begin
						out_valid <= 1'b1;
						path      <= stack[sp_dec[3:0]];
						sp        <= sp_dec;
						first_q   <= 1'b0;
						if (first_q)
							worst_delay <= worst_q;
					end else begin
						st         <= TR_IDLE;
						trace_done <= 1'b1;
					end
				end
				default: st <= TR_IDLE;
			endcase
		end
	end

endmodule

/* sta_relax.sv */
// STA relax engine, repeated longest-path sweeps over the edge list
`timescale 1ns/1ps

module sta_relax
	import sta_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        relax_start,
	input  edge_t       edge_rd,
	input  node_entry_t src_entry,
	input  node_entry_t dst_entry,
	input  delay_t      dst_delay,
	output edge_idx_t   edge_idx,
	output node_wr_t    relax_wr,
	output logic        relax_done
);

	logic                         busy;
	logic                         changed;
	logic [$clog2(NUM_NODES)-1:0] sweep;
	edge_idx_t                    idx;
	arrival_t                     cand;
	logic                         take;
	logic                         last_edge;

	assign edge_idx = idx;

	//----------------------------------------------------------------------
	// Relaxation of the current edge
	//----------------------------------------------------------------------
	assign cand = src_entry.arrival + arrival_t'(dst_delay);
	assign take = busy && src_entry.reached &&
		(!dst_entry.reached || (cand > dst_entry.arrival));

	always_comb begin
		relax_wr               = '0;
		relax_wr.en            = take;
		relax_wr.node          = edge_rd.dst;
		relax_wr.entry.reached = 1'b1;
		relax_wr.entry.arrival = cand;
		relax_wr.entry.pred    = edge_rd.src;
	end

	assign last_edge = (idx == edge_idx_t'(NUM_EDGES - 1));

	//----------------------------------------------------------------------
	// Sweep sequencing
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			changed    <= 1'b0;
			sweep      <= '0;
			idx        <= '0;
			relax_done <= 1'b0;
		end else begin
			relax_done <= 1'b0;
			if (relax_start) begin
				busy    <= 1'b1;
				changed <= 1'b0;
				sweep   <= '0;
				idx     <= '0;
			end else if (busy) begin
				idx <= idx + 5'd1;
				if (last_edge) begin
					// Quiet sweep ends the phase, 16 sweeps bound any DAG here
					if (!(changed || take) || sweep == NUM_NODES - 1) begin
						busy       <= 1'b0;
						relax_done <= 1'b1;
					end
					changed <= 1'b0;
					sweep   <= sweep + 1'b1;
				end else begin
					changed <= changed | take;
				end
			end
		end
	end

endmodule

/* sta_node_table.sv */
// STA node table, per-node delay, arrival, reached flag and predecessor
`timescale 1ns/1ps

module sta_node_table
	import sta_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  node_wr_t    load_wr,
	input  node_wr_t    relax_wr,
	input  node_t       rd_node_a,
	input  node_t       rd_node_b,
	output node_entry_t rd_a,
	output node_entry_t rd_b,
	output node_entry_t rd_dst,
	input  node_t       rd_dst_node,
	output delay_t      delay_rd
);

	logic [NUM_NODES-1:0] reached_q;
	arrival_t             arr_mem   [NUM_NODES];
	node_t                pred_mem  [NUM_NODES];
	delay_t               delay_mem [NUM_NODES];
	node_wr_t             wr;

	// Load and relax phases never overlap
	assign wr = load_wr.en ? load_wr : relax_wr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			reached_q <= '0;
		else if (wr.en)
			reached_q[wr.node] <= wr.entry.reached;
	end

	always_ff @(posedge clk) begin
		if (wr.en) begin
			arr_mem[wr.node]  <= wr.entry.arrival;
			pred_mem[wr.node] <= wr.entry.pred;
		end
	end

	// Seed arrival holds the gate delay
	always_ff @(posedge clk) begin
		if (load_wr.en)
			delay_mem[load_wr.node] <= delay_t'(load_wr.entry.arrival);
	end

	//----------------------------------------------------------------------
	// Combinational read ports
	//----------------------------------------------------------------------
	function automatic node_entry_t read_entry(input node_t n);
		node_entry_t e;
		e.reached = reached_q[n];
		e.arrival = arr_mem[n];
		e.pred    = pred_mem[n];
		return e;
	endfunction

	assign rd_a     = read_entry(rd_node_a);
	assign rd_b     = read_entry(rd_node_b);
	assign rd_dst   = read_entry(rd_dst_node);
	assign delay_rd = delay_mem[rd_dst_node];

	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_wr.en && relax_wr.en))
		else $error("loader and relax engine write the node table together");

endmodule

/* sta_loader.sv */
// STA input loader, stores the edge list and seeds each node with its gate delay
`timescale 1ns/1ps

module sta_loader
	import sta_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  delay_t    delay,
	input  node_t     source,
	input  node_t     destination,
	input  edge_idx_t edge_idx,
	output edge_t     edge_rd,
	output node_wr_t  node_wr,
	output logic      load_done
);

	edge_idx_t cnt;
	edge_t     edge_mem [NUM_EDGES];

	// Input cycle counter, wraps back to zero after the last edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt       <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= in_valid && (cnt == edge_idx_t'(NUM_EDGES - 1));
			if (in_valid)
				cnt <= cnt + 5'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			edge_mem[cnt] <= '{src: source, dst: destination};
	end

	assign edge_rd = edge_mem[edge_idx];

	// Seed write for the first 16 cycles
	// arrival carries the gate delay here, the node table keeps a copy of it
	always_comb begin
		node_wr               = '0;
		node_wr.en            = in_valid && (cnt < edge_idx_t'(NUM_NODES));
		node_wr.node          = cnt[3:0];
		node_wr.entry.reached = (cnt[3:0] == SRC_NODE);
		node_wr.entry.arrival = arrival_t'(delay);
		node_wr.entry.pred    = SRC_NODE;
	end

	//----------------------------------------------------------------------
	// Input window is exactly NUM_EDGES cycles long
	//----------------------------------------------------------------------
	a_window_end: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid && cnt == edge_idx_t'(NUM_EDGES - 1)) |=> !in_valid)
		else $error("in_valid high after the last edge of a run");

	a_window_gap: assert property (@(posedge clk) disable iff (!rst_n)
		(cnt != '0) |-> in_valid)
		else $error("in_valid dropped in the middle of a run");

endmodule

/* sta_pkg.sv */
// STA package with graph sizes, node constants, data types and controller states
package sta_pkg;

	//----------------------------------------------------------------------
	// Graph sizes and fixed endpoints
	//----------------------------------------------------------------------
	localparam int NUM_NODES = 16;
	localparam int NUM_EDGES = 32;

	typedef logic [3:0] node_t;
	typedef logic [3:0] delay_t;
	typedef logic [7:0] arrival_t;
	typedef logic [4:0] edge_idx_t;

	localparam node_t SRC_NODE  = 4'd0;
	localparam node_t SINK_NODE = 4'd1;

	//----------------------------------------------------------------------
	// Structs
	//----------------------------------------------------------------------
	typedef struct packed {
		node_t src;
		node_t dst;
	} edge_t;

	// Per-node timing state
	typedef struct packed {
		logic     reached;
		arrival_t arrival;
		node_t    pred;
	} node_entry_t;

	typedef struct packed {
		logic        en;
		node_t       node;
		node_entry_t entry;
	} node_wr_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		RELAX,
		TRACE,
		OUTPUT
	} sta_state_t;

endpackage
